// ==== design/noc_flit_pkg.sv ====
// Flit and link formats; coordinates are unsigned and a flit carries no header beyond dst and src
`default_nettype none

package noc_flit_pkg;

  // Bits per mesh axis
  localparam int CoordWidth = 4;
  localparam int PayloadWidth = 32;

  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } coord_t;

  // Single-flit packet with dst in the top bits
  typedef struct packed {
    coord_t                  dst;
    coord_t                  src;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

  // One flit per cycle on a link qualified by valid
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

  // Write of the node's own coordinate
  typedef struct packed {
    logic   en;
    coord_t node;
  } cfg_write_t;

endpackage

`default_nettype wire

// ==== design/noc_router_pkg.sv ====
// Router structure for a five-port mesh node; BufDepth must be a power of two and at least 2
`default_nettype none

package noc_router_pkg;

  localparam int NumPorts = 5;

  // Port indices shared by inputs and outputs
  typedef enum logic [2:0] {
    Eject = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } port_e;

  // Input buffer depth and the credits an output starts with
  localparam int BufDepth = 4;

  // Wide enough to hold BufDepth itself
  localparam int CreditWidth = $clog2(BufDepth + 1);

  // One bit per port for requests and grants
  typedef logic [NumPorts-1:0] port_mask_t;

endpackage

`default_nettype wire

// ==== design/router_cfg_regs.sv ====
// Node coordinate register; it is zero after reset and routing is wrong until software writes it
`timescale 1ns/1ps
`default_nettype none

module router_cfg_regs (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  noc_flit_pkg::cfg_write_t cfg_i,
  output noc_flit_pkg::coord_t     node_o
);

  noc_flit_pkg::coord_t node_q;

  // Write takes effect on the edge after the request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      node_q <= '0;
    end else if (cfg_i.en) begin
      node_q <= cfg_i.node;
    end
  end

  // Fanned out to every input port for the XY decision
  assign node_o = node_q;

endmodule

`default_nettype wire

// ==== design/router_input_port.sv ====
// Input buffer with XY routing; relies on the upstream credit count, so a full buffer is never written
`timescale 1ns/1ps
`default_nettype none

module router_input_port (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  noc_flit_pkg::link_t        link_i,
  output logic                       credit_o,
  input  noc_flit_pkg::coord_t       node_i,
  output noc_flit_pkg::flit_t        head_o,
  output noc_router_pkg::port_mask_t req_o,
  input  noc_router_pkg::port_mask_t grant_i
);

  noc_flit_pkg::flit_t mem [noc_router_pkg::BufDepth];

  logic [$clog2(noc_router_pkg::BufDepth)-1:0] wr_ptr_q;
  logic [$clog2(noc_router_pkg::BufDepth)-1:0] rd_ptr_q;
  logic [noc_router_pkg::CreditWidth-1:0]      count_q;

  logic push;
  logic pop;

  assign push = link_i.valid;
  // At most one output grants us, and only while we request
  assign pop  = |grant_i;

  // Flit storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= link_i.flit;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_o = mem[rd_ptr_q];

  // Settle x first, then y, then eject
  always_comb begin
    req_o = '0;
    if (count_q != '0) begin
      if (head_o.dst.x > node_i.x) begin
        req_o[noc_router_pkg::East] = 1'b1;
      end else if (head_o.dst.x < node_i.x) begin
        req_o[noc_router_pkg::West] = 1'b1;
      end else if (head_o.dst.y > node_i.y) begin
        req_o[noc_router_pkg::North] = 1'b1;
      end else if (head_o.dst.y < node_i.y) begin
        req_o[noc_router_pkg::South] = 1'b1;
      end else begin
        req_o[noc_router_pkg::Eject] = 1'b1;
      end
    end
  end

  // One credit back upstream per freed slot
  assign credit_o = pop;

endmodule

`default_nettype wire

// ==== design/router_output_port.sv ====
// Output arbiter and register; the neighbour must return exactly one credit per flit it drains
`timescale 1ns/1ps
`default_nettype none

module router_output_port (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  noc_router_pkg::port_mask_t                         req_i,
  input  noc_flit_pkg::flit_t [noc_router_pkg::NumPorts-1:0] flit_i,
  output noc_router_pkg::port_mask_t                         grant_o,
  output noc_flit_pkg::link_t                                link_o,
  input  logic                                               credit_i
);

  noc_router_pkg::port_e prio_q;
  noc_router_pkg::port_e winner;
  logic                  any_grant;

  logic [noc_router_pkg::CreditWidth-1:0] credit_q;
  logic [noc_router_pkg::CreditWidth-1:0] credit_d;

  logic                valid_q;
  noc_flit_pkg::flit_t flit_q;

  // Round robin search upward from the priority pointer
  always_comb begin : arbitrate
    int   idx;
    logic found;
    found  = 1'b0;
    winner = prio_q;
    for (int off = 0; off < noc_router_pkg::NumPorts; off++) begin
      idx = int'(prio_q) + off;
      if (idx >= noc_router_pkg::NumPorts) begin
        idx = idx - noc_router_pkg::NumPorts;
      end
      if (!found && req_i[idx]) begin
        found  = 1'b1;
        winner = noc_router_pkg::port_e'(idx);
      end
    end
    // No credit left downstream, so nobody wins
    any_grant = found && (credit_q != '0);
    grant_o   = '0;
    if (any_grant) begin
      grant_o[winner] = 1'b1;
    end
  end

  // Grant and returning credit may land in the same cycle
  always_comb begin
    case ({any_grant, credit_i})
      2'b10:   credit_d = credit_q - 1'b1;
      2'b01:   credit_d = credit_q + 1'b1;
      default: credit_d = credit_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q   <= noc_router_pkg::Eject;
      credit_q <= noc_router_pkg::CreditWidth'(noc_router_pkg::BufDepth);
      valid_q  <= 1'b0;
    end else begin
      credit_q <= credit_d;
      valid_q  <= any_grant;
      if (any_grant) begin
        // Pointer moves just past the winner
        if (int'(winner) == noc_router_pkg::NumPorts - 1) begin
          prio_q <= noc_router_pkg::Eject;
        end else begin
          prio_q <= noc_router_pkg::port_e'(int'(winner) + 1);
        end
      end
    end
  end

  // Payload register qualified by valid_q
  always_ff @(posedge clk_i) begin
    if (any_grant) begin
      flit_q <= flit_i[winner];
    end
  end

  assign link_o.valid = valid_q;
  assign link_o.flit  = flit_q;

endmodule

`default_nettype wire

// ==== design/noc_router.sv ====
// Five-port XY mesh router with credit flow control; a local flit addressed to its own node is unsupported
`timescale 1ns/1ps
`default_nettype none

module noc_router (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  noc_flit_pkg::cfg_write_t                           cfg_i,
  input  noc_flit_pkg::link_t [noc_router_pkg::NumPorts-1:0] in_link_i,
  output noc_router_pkg::port_mask_t                         in_credit_o,
  output noc_flit_pkg::link_t [noc_router_pkg::NumPorts-1:0] out_link_o,
  input  noc_router_pkg::port_mask_t                         out_credit_i
);

  noc_flit_pkg::coord_t node;

  // Indexed by input, bits by output
  noc_router_pkg::port_mask_t [noc_router_pkg::NumPorts-1:0] req;
  noc_router_pkg::port_mask_t [noc_router_pkg::NumPorts-1:0] grant_in;
  // Indexed by output, bits by input
  noc_router_pkg::port_mask_t [noc_router_pkg::NumPorts-1:0] req_out;
  noc_router_pkg::port_mask_t [noc_router_pkg::NumPorts-1:0] grant_out;

  noc_flit_pkg::flit_t [noc_router_pkg::NumPorts-1:0] head;

  router_cfg_regs i_cfg_regs (
    .clk_i  ( clk_i ),
    .rst_i  ( rst_i ),
    .cfg_i  ( cfg_i ),
    .node_o ( node  )
  );

  for (genvar in = 0; in < noc_router_pkg::NumPorts; in++) begin : gen_input
    router_input_port i_input_port (
      .clk_i    ( clk_i           ),
      .rst_i    ( rst_i           ),
      .link_i   ( in_link_i[in]   ),
      .credit_o ( in_credit_o[in] ),
      .node_i   ( node            ),
      .head_o   ( head[in]        ),
      .req_o    ( req[in]         ),
      .grant_i  ( grant_in[in]    )
    );

    // Swap the two matrix axes
    for (genvar out = 0; out < noc_router_pkg::NumPorts; out++) begin : gen_xpose
      assign req_out[out][in]  = req[in][out];
      assign grant_in[in][out] = grant_out[out][in];
    end
  end

  for (genvar out = 0; out < noc_router_pkg::NumPorts; out++) begin : gen_output
    router_output_port i_output_port (
      .clk_i    ( clk_i             ),
      .rst_i    ( rst_i             ),
      .req_i    ( req_out[out]      ),
      .flit_i   ( head              ),
      .grant_o  ( grant_out[out]    ),
      .link_o   ( out_link_o[out]   ),
      .credit_i ( out_credit_i[out] )
    );
  end

endmodule

`default_nettype wire

// ==== include/noc_tb_cases.svh ====
// Routing cases for the router testbench; rows never send a local flit to its own node
`ifndef NOC_TB_CASES_SVH
`define NOC_TB_CASES_SVH

typedef struct packed {
  noc_flit_pkg::coord_t  node;
  noc_router_pkg::port_e in_port;
  noc_flit_pkg::coord_t  dst;
  noc_router_pkg::port_e exp_port;
} tb_case_t;

localparam int NumCases = 12;

// Node {x, y}, input port, destination {x, y}, expected output
localparam tb_case_t Cases [NumCases] = '{
  '{'{4'd2, 4'd2}, noc_router_pkg::Eject, '{4'd3, 4'd2}, noc_router_pkg::East},
  '{'{4'd2, 4'd2}, noc_router_pkg::Eject, '{4'd0, 4'd2}, noc_router_pkg::West},
  '{'{4'd2, 4'd2}, noc_router_pkg::Eject, '{4'd2, 4'd3}, noc_router_pkg::North},
  '{'{4'd2, 4'd2}, noc_router_pkg::Eject, '{4'd2, 4'd0}, noc_router_pkg::South},
  '{'{4'd1, 4'd1}, noc_router_pkg::West,  '{4'd3, 4'd1}, noc_router_pkg::East},
  '{'{4'd1, 4'd1}, noc_router_pkg::West,  '{4'd1, 4'd1}, noc_router_pkg::Eject},
  '{'{4'd3, 4'd0}, noc_router_pkg::South, '{4'd3, 4'd2}, noc_router_pkg::North},
  '{'{4'd3, 4'd4}, noc_router_pkg::North, '{4'd3, 4'd1}, noc_router_pkg::South},
  '{'{4'd5, 4'd5}, noc_router_pkg::East,  '{4'd0, 4'd7}, noc_router_pkg::West},
  '{'{4'd0, 4'd0}, noc_router_pkg::South, '{4'd0, 4'd0}, noc_router_pkg::Eject},
  '{'{4'd4, 4'd2}, noc_router_pkg::West,  '{4'd9, 4'd6}, noc_router_pkg::East},
  '{'{4'd6, 4'd6}, noc_router_pkg::East,  '{4'd6, 4'd9}, noc_router_pkg::North}
};

`endif

// ==== dv/tb_noc_router.sv ====
// Router testbench; one routing case in flight at a time, node coordinate rewritten per table row
`timescale 1ns/1ps
`default_nettype none

module tb_noc_router;

  `include "noc_tb_cases.svh"

  localparam int WatchdogCycles = NumCases * 40 + 400;

  logic                                               clk;
  logic                                               rst;
  noc_flit_pkg::cfg_write_t                           cfg;
  noc_flit_pkg::link_t [noc_router_pkg::NumPorts-1:0] in_link;
  noc_flit_pkg::link_t [noc_router_pkg::NumPorts-1:0] out_link;
  noc_router_pkg::port_mask_t                         in_credit;
  noc_router_pkg::port_mask_t                         out_credit;

  // Flits seen on each output and the cycle each was seen in
  noc_flit_pkg::flit_t rx_q   [noc_router_pkg::NumPorts][$];
  int                  rx_cyc [noc_router_pkg::NumPorts][$];
  int                  in_cyc     [noc_router_pkg::NumPorts];
  int                  sent_cnt   [noc_router_pkg::NumPorts];
  int                  credit_cnt [noc_router_pkg::NumPorts];
  int                  owed       [noc_router_pkg::NumPorts];
  logic [noc_router_pkg::NumPorts-1:0] hold;
  int                  cyc;

  noc_router u_noc_router (
    .clk_i        ( clk        ),
    .rst_i        ( rst        ),
    .cfg_i        ( cfg        ),
    .in_link_i    ( in_link    ),
    .in_credit_o  ( in_credit  ),
    .out_link_o   ( out_link   ),
    .out_credit_i ( out_credit )
  );

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // XY order with x first, then y, then eject
  function automatic noc_router_pkg::port_e xy_route(input noc_flit_pkg::coord_t node,
                                                     input noc_flit_pkg::coord_t dst);
    if (dst.x > node.x) return noc_router_pkg::East;
    if (dst.x < node.x) return noc_router_pkg::West;
    if (dst.y > node.y) return noc_router_pkg::North;
    if (dst.y < node.y) return noc_router_pkg::South;
    return noc_router_pkg::Eject;
  endfunction

  function automatic noc_flit_pkg::flit_t make_flit(input noc_flit_pkg::coord_t dst);
    noc_flit_pkg::flit_t f;
    logic [7:0]          rnd;
    rnd       = 8'($urandom);
    f.dst     = dst;
    f.src     = rnd;
    f.payload = $urandom;
    return f;
  endfunction

  // Upstream credits left for one DUT input
  function automatic int avail(input int p);
    return noc_router_pkg::BufDepth - sent_cnt[p] + credit_cnt[p];
  endfunction

  task automatic write_node(input noc_flit_pkg::coord_t node);
    @(posedge clk);
    cfg <= '{en: 1'b1, node: node};
    @(posedge clk);
    cfg.en <= 1'b0;
  endtask

  task automatic send_flit(input int p, input noc_flit_pkg::flit_t f);
    @(posedge clk);
    while (avail(p) == 0) begin
      @(posedge clk);
    end
    in_link[p] <= '{valid: 1'b1, flit: f};
    sent_cnt[p]++;
    @(posedge clk);
    in_link[p].valid <= 1'b0;
  endtask

  task automatic wait_rx(input int p, input int n);
    while (rx_q[p].size() < n) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic expect_idle_outputs();
    for (int p = 0; p < noc_router_pkg::NumPorts; p++) begin
      check_value("out_link_o extra flits", 64'(rx_q[p].size()), 64'(0));
    end
  endtask

  // Records outputs and injections, and plays the downstream neighbours
  always @(posedge clk) begin
    if (rst) begin
      out_credit <= '0;
      cyc = 0;
    end else begin
      cyc = cyc + 1;
      for (int p = 0; p < noc_router_pkg::NumPorts; p++) begin
        if (in_link[p].valid) in_cyc[p] = cyc;
        if (in_credit[p]) credit_cnt[p]++;
        if (out_link[p].valid) begin
          rx_q[p].push_back(out_link[p].flit);
          rx_cyc[p].push_back(cyc);
          owed[p]++;
        end
        if (!hold[p] && owed[p] > 0) begin
          out_credit[p] <= 1'b1;
          owed[p]--;
        end else begin
          out_credit[p] <= 1'b0;
        end
      end
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", WatchdogCycles);
    $display("Verification failed");
    $fatal(1);
  end

  initial begin
    noc_router_pkg::port_e exp_port;
    noc_flit_pkg::flit_t   f;
    noc_flit_pkg::flit_t   got;
    noc_flit_pkg::flit_t   bp_q [$];
    noc_flit_pkg::flit_t   cont_f [4];
    int                    lat;
    int                    hits;
    void'($urandom(23));
    clk = 1'b0;
    rst = 1'b1;
    cfg = '0;
    in_link = '0;
    out_credit = '0;
    hold = '0;
    for (int p = 0; p < noc_router_pkg::NumPorts; p++) begin
      sent_cnt[p] = 0;
      credit_cnt[p] = 0;
      owed[p] = 0;
      in_cyc[p] = 0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Quiet links right after reset
    repeat (3) begin
      @(posedge clk);
      for (int p = 0; p < noc_router_pkg::NumPorts; p++) begin
        check_value("out_link_o.valid", 64'(out_link[p].valid), 64'(0));
      end
      check_value("in_credit_o", 64'(in_credit), 64'(0));
    end

    for (int i = 0; i < NumCases; i++) begin
      exp_port = xy_route(Cases[i].node, Cases[i].dst);
      check_value("case exp_port", 64'(Cases[i].exp_port), 64'(exp_port));
      write_node(Cases[i].node);
      f = make_flit(Cases[i].dst);
      send_flit(int'(Cases[i].in_port), f);
      wait_rx(int'(exp_port), 1);
      got = rx_q[exp_port].pop_front();
      lat = rx_cyc[exp_port].pop_front() - in_cyc[Cases[i].in_port];
      check_value("out_link_o.flit", 64'(got), 64'(f));
      check_value("out_link_o.valid latency", 64'(lat), 64'(2));
      expect_idle_outputs();
    end

    // East neighbour keeps its credits until the output stalls
    write_node('{x: 4'd2, y: 4'd2});
    hold[noc_router_pkg::East] <= 1'b1;
    for (int i = 0; i < noc_router_pkg::BufDepth + 2; i++) begin
      bp_q.push_back(make_flit('{x: 4'd5, y: 4'd2}));
      send_flit(int'(noc_router_pkg::West), bp_q[i]);
    end
    wait_rx(int'(noc_router_pkg::East), noc_router_pkg::BufDepth);
    repeat (20) @(posedge clk);
    check_value("East flits while stalled", 64'(rx_q[noc_router_pkg::East].size()),
                64'(noc_router_pkg::BufDepth));
    hold[noc_router_pkg::East] <= 1'b0;
    wait_rx(int'(noc_router_pkg::East), noc_router_pkg::BufDepth + 2);
    foreach (bp_q[i]) begin
      got = rx_q[noc_router_pkg::East].pop_front();
      check_value("out_link_o.flit in order", 64'(got), 64'(bp_q[i]));
    end
    rx_cyc[noc_router_pkg::East].delete();
    expect_idle_outputs();

    // Four inputs race for East in one cycle
    foreach (cont_f[k]) cont_f[k] = make_flit('{x: 4'd5, y: 4'd2});
    fork
      send_flit(int'(noc_router_pkg::North), cont_f[0]);
      send_flit(int'(noc_router_pkg::South), cont_f[1]);
      send_flit(int'(noc_router_pkg::West), cont_f[2]);
      send_flit(int'(noc_router_pkg::Eject), cont_f[3]);
    join
    wait_rx(int'(noc_router_pkg::East), 4);
    repeat (4) @(posedge clk);
    check_value("East flits after contention", 64'(rx_q[noc_router_pkg::East].size()), 64'(4));
    foreach (cont_f[k]) begin
      hits = 0;
      foreach (rx_q[noc_router_pkg::East][j]) begin
        if (rx_q[noc_router_pkg::East][j] == cont_f[k]) hits++;
      end
      check_value("contention flit hits", 64'(hits), 64'(1));
    end
    rx_q[noc_router_pkg::East].delete();
    rx_cyc[noc_router_pkg::East].delete();
    expect_idle_outputs();

    repeat (10) @(posedge clk);
    for (int p = 0; p < noc_router_pkg::NumPorts; p++) begin
      check_value("in_credit_o pulses", 64'(credit_cnt[p]), 64'(sent_cnt[p]));
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
design/noc_flit_pkg.sv
design/noc_router_pkg.sv
design/router_cfg_regs.sv
design/router_input_port.sv
design/router_output_port.sv
design/noc_router.sv
dv/tb_noc_router.sv

// ==== Makefile ====
TB_TOP := tb_noc_router

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module noc_router \
		design/noc_flit_pkg.sv design/noc_router_pkg.sv design/router_cfg_regs.sv \
		design/router_input_port.sv design/router_output_port.sv design/noc_router.sv

sim:
	verilator --binary --timing -f list.f --top-module $(TB_TOP) -o V$(TB_TOP)
	./obj_dir/V$(TB_TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir
